// ==== cfg_reg_port.sv ====
// Configuration register port
// Holds the LLC cache window registers, maps the event counters for read
// and clear, and answers unmapped reads with a fixed pattern

`timescale 1ns/10ps

module cfg_reg_port
  import host_event_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  reg_req_t    req_i,
  output reg_rsp_t    rsp_o,
  output llc_window_t window_o,
  output logic        cnt_clr_o,
  output cnt_idx_t    cnt_clr_idx_o,
  output cnt_idx_t    cnt_rd_idx_o,
  input  data_t       cnt_rd_data_i
);

  reg_addr_t   cnt_off;
  logic        cnt_hit;
  cnt_idx_t    cnt_idx;
  llc_window_t window_q;
  data_t       rdata_d;
  data_t       rdata_q;
  logic        rvalid_q;

  // Counter window, word aligned only
  assign cnt_off = req_i.addr - CNT_BASE_ADDR;
  assign cnt_hit = (cnt_off < reg_addr_t'(NUM_COUNTERS * 4)) && (cnt_off[1:0] == 2'b00);
  assign cnt_idx = cnt_off[4:2];

  // Any write to a counter slot clears it
  assign cnt_clr_o     = req_i.wr && cnt_hit;
  assign cnt_clr_idx_o = cnt_idx;
  assign cnt_rd_idx_o  = cnt_idx;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      window_q <= '0;
    end else if (req_i.wr) begin
      case (req_i.addr)
        REG_CACHE_START: window_q.cache_start <= req_i.wdata;
        REG_CACHE_END:   window_q.cache_end   <= req_i.wdata;
        REG_SPM_START:   window_q.spm_start   <= req_i.wdata;
        default: ;
      endcase
    end
  end

  // Read mux
  always_comb begin
    if (cnt_hit) begin
      rdata_d = cnt_rd_data_i;
    end else begin
      case (req_i.addr)
        REG_CACHE_START: rdata_d = window_q.cache_start;
        REG_CACHE_END:   rdata_d = window_q.cache_end;
        REG_SPM_START:   rdata_d = window_q.spm_start;
        default:         rdata_d = UNMAPPED_RDATA;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.rd;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.rd) begin
      rdata_q <= rdata_d;
    end
  end

  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign window_o     = window_q;

  a_no_wr_rd : assert property (@(posedge clk_i) disable iff (rst_i)
                                !(req_i.wr && req_i.rd))
    else $error("register write and read strobed in the same cycle");

endmodule

// ==== event_counters.sv ====
// Event counter bank
// One wrapping 32-bit counter per event strobe, with an indexed
// combinational read and an indexed clear that wins over an increment

`timescale 1ns/10ps

module event_counters
  import host_event_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_i,
  input  evt_vec_t evt_i,
  input  logic     clr_i,
  input  cnt_idx_t clr_idx_i,
  input  cnt_idx_t rd_idx_i,
  output data_t    rd_data_o
);

  data_t cnt_q [NUM_COUNTERS];
  logic  clr_sel [NUM_COUNTERS];

  // Decode which counter the clear targets
  always_comb begin
    for (int i = 0; i < NUM_COUNTERS; i++) begin
      clr_sel[i] = clr_i && (clr_idx_i == cnt_idx_t'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NUM_COUNTERS; i++) begin
      if (rst_i) begin
        cnt_q[i] <= '0;
      end else if (clr_sel[i]) begin
        cnt_q[i] <= '0;
      end else if (evt_i[i]) begin
        // Wraps at 2^32
        cnt_q[i] <= cnt_q[i] + data_t'(1);
      end
    end
  end

  assign rd_data_o = cnt_q[rd_idx_i];

endmodule

// ==== evt_sync_rx.sv ====
// DMA event receiver
// Brings the cluster-side valid level into this clock domain, returns it
// as the acknowledge and produces one event pulse per handshake

`timescale 1ns/10ps

module evt_sync_rx
  import host_event_pkg::*;
(
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic ack_o,
  output logic evt_o
);

  logic [1:0] sync_q;
  logic       ack_q;
  logic       evt_q;

  // Two-stage synchronizer, second stage doubles as ack
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q <= '0;
      ack_q  <= 1'b0;
      evt_q  <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], valid_i};
      ack_q  <= sync_q[1];
      // Rising edge of ack, one cycle late
      evt_q  <= sync_q[1] & ~ack_q;
    end
  end

  assign ack_o = sync_q[1];
  assign evt_o = evt_q;

  // One pulse per handshake, never back to back
  a_evt_single : assert property (@(posedge clk_i) disable iff (rst_i) evt_o |=> !evt_o)
    else $error("dma event pulse lasted more than one cycle");

endmodule

// ==== host_event_pkg.sv ====
// Host event package
// Widths, address map, register map and bundle types shared by the
// LLC event and configuration slice of the host domain

package host_event_pkg;

  // Plain vector types
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [7:0]  reg_addr_t;
  typedef logic [2:0]  cnt_idx_t;
  typedef logic [7:0]  evt_vec_t;
  // Bit 0 debug, bit 1 hyper, bit 2 unmapped
  typedef logic [2:0]  region_evt_t;

  // Event strobes coming from the LLC
  typedef struct packed {
    logic rd_hit;
    logic rd_miss;
    logic wr_hit;
    logic wr_miss;
  } llc_evt_t;

  // Single-cycle register strobes, no back-pressure
  typedef struct packed {
    logic      wr;
    logic      rd;
    reg_addr_t addr;
    data_t     wdata;
  } reg_req_t;

  typedef struct packed {
    logic  rvalid;
    data_t rdata;
  } reg_rsp_t;

  // Cache window handed to the LLC
  typedef struct packed {
    data_t cache_start;
    data_t cache_end;
    data_t spm_start;
  } llc_window_t;

  localparam int unsigned NUM_COUNTERS = 8;

  // Counter slots
  localparam cnt_idx_t CNT_RD_HIT   = 3'd0;
  localparam cnt_idx_t CNT_RD_MISS  = 3'd1;
  localparam cnt_idx_t CNT_WR_HIT   = 3'd2;
  localparam cnt_idx_t CNT_WR_MISS  = 3'd3;
  localparam cnt_idx_t CNT_DMA      = 3'd4;
  localparam cnt_idx_t CNT_DEBUG    = 3'd5;
  localparam cnt_idx_t CNT_HYPER    = 3'd6;
  localparam cnt_idx_t CNT_UNMAPPED = 3'd7;

  // Memory map rules
  localparam addr_t DEBUG_BASE   = 32'h0000_0000;
  localparam addr_t HYPER_BASE   = 32'h8000_0000;
  localparam addr_t HYPER_LENGTH = 32'h4000_0000;

  // Register map, counter i sits at CNT_BASE_ADDR + 4*i
  localparam reg_addr_t REG_CACHE_START = 8'h00;
  localparam reg_addr_t REG_CACHE_END   = 8'h04;
  localparam reg_addr_t REG_SPM_START   = 8'h08;
  localparam reg_addr_t CNT_BASE_ADDR   = 8'h10;

  localparam data_t UNMAPPED_RDATA = 32'hDEADF000;

endpackage

// ==== host_event_tb_tasks.svh ====
// Host event testbench tasks
// Register driver, compare tasks, reference region rules and the
// directed tests, included inside the testbench module

`ifndef HOST_EVENT_TB_TASKS_SVH
`define HOST_EVENT_TB_TASKS_SVH

// Every task starts and ends 1 ns after a rising edge
task automatic next_cycle();
  @(posedge clk);
  #1;
endtask

task automatic check_bit(string name, logic got, logic exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
  end
endtask

task automatic check_data(string name, data_t got, data_t exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
  end
endtask

task automatic check_window(string name, llc_window_t got, llc_window_t exp);
  chk_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
  end
endtask

task automatic reg_write(reg_addr_t addr, data_t wdata);
  reg_req.wr    = 1'b1;
  reg_req.addr  = addr;
  reg_req.wdata = wdata;
  next_cycle();
  reg_req.wr    = 1'b0;
endtask

task automatic reg_read(reg_addr_t addr, output data_t rdata);
  reg_req.rd   = 1'b1;
  reg_req.addr = addr;
  next_cycle();
  reg_req.rd   = 1'b0;
  rdata        = reg_rsp.rdata;
  if (reg_rsp.rvalid !== 1'b1) begin
    err_cnt++;
    $display("Error: read of register 0x%h gave no rvalid one cycle after the strobe", addr);
  end
endtask

task automatic check_all_counters();
  data_t got;
  for (int i = 0; i < NUM_COUNTERS; i++) begin
    reg_read(CNT_BASE_ADDR + reg_addr_t'(4 * i), got);
    check_data($sformatf("counter[%0d]", i), got, exp_cnt[i]);
  end
endtask

// Region rules of the address map
function automatic cnt_idx_t region_slot(addr_t addr);
  longint a;
  a = longint'(addr);
  if (a >= longint'(DEBUG_BASE) && a < longint'(HYPER_BASE)) begin
    return CNT_DEBUG;
  end
  if (a >= longint'(HYPER_BASE) && a < longint'(HYPER_BASE) + longint'(HYPER_LENGTH)) begin
    return CNT_HYPER;
  end
  return CNT_UNMAPPED;
endfunction

task automatic wait_ack(logic level);
  int n;
  n = 0;
  while (dma_evt_ack !== level && n < 16) begin
    next_cycle();
    n++;
  end
  if (dma_evt_ack !== level) begin
    err_cnt++;
    $display("Error: dma_evt_ack_o did not go to %0b within 16 cycles", level);
  end
endtask

task automatic test_reset_values();
  data_t got;
  check_bit("reg_rsp_o.rvalid", reg_rsp.rvalid, 1'b0);
  check_bit("dma_evt_ack_o", dma_evt_ack, 1'b0);
  check_window("llc_window_o", llc_window, '0);
  reg_read(REG_CACHE_START, got);
  check_data("cache_start", got, '0);
  reg_read(REG_CACHE_END, got);
  check_data("cache_end", got, '0);
  reg_read(REG_SPM_START, got);
  check_data("spm_start", got, '0);
  check_all_counters();
endtask

task automatic test_window_regs();
  llc_window_t exp;
  data_t       got;
  exp = '0;
  exp.cache_start = rand_bits(32);
  reg_write(REG_CACHE_START, exp.cache_start);
  check_window("llc_window_o", llc_window, exp);
  exp.cache_end = rand_bits(32);
  reg_write(REG_CACHE_END, exp.cache_end);
  check_window("llc_window_o", llc_window, exp);
  exp.spm_start = rand_bits(32);
  reg_write(REG_SPM_START, exp.spm_start);
  check_window("llc_window_o", llc_window, exp);
  reg_read(REG_CACHE_START, got);
  check_data("cache_start", got, exp.cache_start);
  reg_read(REG_CACHE_END, got);
  check_data("cache_end", got, exp.cache_end);
  reg_read(REG_SPM_START, got);
  check_data("spm_start", got, exp.spm_start);
  reg_read(8'h0C, got);
  check_data("rdata at 0x0c", got, UNMAPPED_RDATA);
  reg_read(8'h40, got);
  check_data("rdata at 0x40", got, UNMAPPED_RDATA);
endtask

task automatic test_llc_events();
  llc_evt_t ev;
  for (int c = 0; c < 200; c++) begin
    ev = llc_evt_t'(rand_bits(4));
    llc_evt = ev;
    if (ev.rd_hit)  exp_cnt[CNT_RD_HIT]  += 32'd1;
    if (ev.rd_miss) exp_cnt[CNT_RD_MISS] += 32'd1;
    if (ev.wr_hit)  exp_cnt[CNT_WR_HIT]  += 32'd1;
    if (ev.wr_miss) exp_cnt[CNT_WR_MISS] += 32'd1;
    next_cycle();
  end
  llc_evt = '0;
  repeat (3) next_cycle();
  check_all_counters();
  // Clear from the top slot down so the LLC counts stay live longest
  for (int i = NUM_COUNTERS - 1; i >= 0; i--) begin
    reg_write(CNT_BASE_ADDR + reg_addr_t'(4 * i), rand_bits(32));
    exp_cnt[i] = '0;
    check_all_counters();
  end
endtask

task automatic test_region_map();
  addr_t edges [6] = '{32'h0000_0000, 32'h7FFF_FFFC, 32'h8000_0000,
                       32'hBFFF_FFFC, 32'hC000_0000, 32'hFFFF_FFFC};
  addr_t a;
  int    gap;
  for (int k = 0; k < 66; k++) begin
    a = (k < 6) ? edges[k] : rand_bits(32);
    gap = (k < 6) ? 1 : int'(rand_bits(2));
    mem_access_valid = 1'b1;
    mem_addr = a;
    exp_cnt[region_slot(a)] += 32'd1;
    next_cycle();
    mem_access_valid = 1'b0;
    repeat (gap) next_cycle();
  end
  repeat (3) next_cycle();
  check_all_counters();
endtask

task automatic test_dma_handshake();
  data_t got;
  for (int k = 0; k < 5; k++) begin
    dma_evt_valid = 1'b1;
    wait_ack(1'b1);
    dma_evt_valid = 1'b0;
    wait_ack(1'b0);
    exp_cnt[CNT_DMA] += 32'd1;
    // One count per handshake
    repeat (3) next_cycle();
    reg_read(CNT_BASE_ADDR + reg_addr_t'(4 * int'(CNT_DMA)), got);
    check_data("dma counter", got, exp_cnt[CNT_DMA]);
  end
  check_all_counters();
endtask

`endif

// ==== host_event_tb.sv ====
// Host event testbench
// Directed tests for the register port, the LLC and region counters and
// the DMA event handshake, bounded by a cycle watchdog

`timescale 1ns/10ps

module host_event_tb
  import host_event_pkg::*;
();

  localparam int          CLK_HALF_NS     = 4;
  localparam int          RESET_CYCLES    = 16;
  localparam int          WATCHDOG_CYCLES = 6000;
  localparam logic [31:0] LFSR_SEED       = 32'h8516_9a8a;

  logic        clk;
  logic        rst;
  reg_req_t    reg_req;
  reg_rsp_t    reg_rsp;
  logic        mem_access_valid;
  addr_t       mem_addr;
  llc_evt_t    llc_evt;
  logic        dma_evt_valid;
  logic        dma_evt_ack;
  llc_window_t llc_window;

  // Reference model of every counter
  data_t       exp_cnt [NUM_COUNTERS];
  logic [31:0] lfsr_state;
  int          err_cnt;
  int          chk_cnt;

  host_event_top dut (
    .clk_i              ( clk              ),
    .rst_i              ( rst              ),
    .reg_req_i          ( reg_req          ),
    .reg_rsp_o          ( reg_rsp          ),
    .mem_access_valid_i ( mem_access_valid ),
    .mem_addr_i         ( mem_addr         ),
    .llc_evt_i          ( llc_evt          ),
    .dma_evt_valid_i    ( dma_evt_valid    ),
    .dma_evt_ack_o      ( dma_evt_ack      ),
    .llc_window_o       ( llc_window       )
  );

  // Galois LFSR, one step per bit taken
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return out;
  endfunction

  function automatic data_t rand_bits(int n);
    data_t v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  `include "host_event_tb_tasks.svh"

  initial begin
    clk = 1'b0;
    forever #(CLK_HALF_NS) clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Error: watchdog expired after %0d cycles, the tests did not finish",
             WATCHDOG_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    lfsr_state       = LFSR_SEED;
    err_cnt          = 0;
    chk_cnt          = 0;
    rst              = 1'b1;
    reg_req          = '0;
    mem_access_valid = 1'b0;
    mem_addr         = '0;
    llc_evt          = '0;
    dma_evt_valid    = 1'b0;
    for (int i = 0; i < NUM_COUNTERS; i++) begin
      exp_cnt[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;

    test_reset_values();
    test_window_regs();
    test_llc_events();
    test_region_map();
    test_dma_handshake();

    $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== host_event_top.f ====
+incdir+.
host_event_pkg.sv
evt_sync_rx.sv
region_classifier.sv
event_counters.sv
cfg_reg_port.sv
host_event_top.sv
host_event_tb.sv

// ==== host_event_top.sv ====
// Host event top
// Joins the DMA event receiver, the region classifier, the counter bank
// and the configuration register port around the LLC

`timescale 1ns/10ps

module host_event_top
  import host_event_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  reg_req_t    reg_req_i,
  output reg_rsp_t    reg_rsp_o,
  input  logic        mem_access_valid_i,
  input  addr_t       mem_addr_i,
  input  llc_evt_t    llc_evt_i,
  input  logic        dma_evt_valid_i,
  output logic        dma_evt_ack_o,
  output llc_window_t llc_window_o
);

  region_evt_t region_evt;
  logic        dma_evt;
  evt_vec_t    evt_vec;
  logic        cnt_clr;
  cnt_idx_t    cnt_clr_idx;
  cnt_idx_t    cnt_rd_idx;
  data_t       cnt_rd_data;

  // Event vector in counter slot order
  assign evt_vec[CNT_RD_HIT]   = llc_evt_i.rd_hit;
  assign evt_vec[CNT_RD_MISS]  = llc_evt_i.rd_miss;
  assign evt_vec[CNT_WR_HIT]   = llc_evt_i.wr_hit;
  assign evt_vec[CNT_WR_MISS]  = llc_evt_i.wr_miss;
  assign evt_vec[CNT_DMA]      = dma_evt;
  assign evt_vec[CNT_DEBUG]    = region_evt[0];
  assign evt_vec[CNT_HYPER]    = region_evt[1];
  assign evt_vec[CNT_UNMAPPED] = region_evt[2];

  evt_sync_rx i_dma_evt_rx (
    .clk_i   ( clk_i           ),
    .rst_i   ( rst_i           ),
    .valid_i ( dma_evt_valid_i ),
    .ack_o   ( dma_evt_ack_o   ),
    .evt_o   ( dma_evt         )
  );

  region_classifier i_region_classifier (
    .clk_i          ( clk_i              ),
    .rst_i          ( rst_i              ),
    .access_valid_i ( mem_access_valid_i ),
    .addr_i         ( mem_addr_i         ),
    .region_evt_o   ( region_evt         )
  );

  event_counters i_event_counters (
    .clk_i     ( clk_i       ),
    .rst_i     ( rst_i       ),
    .evt_i     ( evt_vec     ),
    .clr_i     ( cnt_clr     ),
    .clr_idx_i ( cnt_clr_idx ),
    .rd_idx_i  ( cnt_rd_idx  ),
    .rd_data_o ( cnt_rd_data )
  );

  cfg_reg_port i_cfg_reg_port (
    .clk_i         ( clk_i        ),
    .rst_i         ( rst_i        ),
    .req_i         ( reg_req_i    ),
    .rsp_o         ( reg_rsp_o    ),
    .window_o      ( llc_window_o ),
    .cnt_clr_o     ( cnt_clr      ),
    .cnt_clr_idx_o ( cnt_clr_idx  ),
    .cnt_rd_idx_o  ( cnt_rd_idx   ),
    .cnt_rd_data_i ( cnt_rd_data  )
  );

endmodule

// ==== region_classifier.sv ====
// Memory access region classifier
// Sorts each access against the debug and hyperbus rules and registers
// one region strobe per access

`timescale 1ns/10ps

module region_classifier
  import host_event_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        access_valid_i,
  input  addr_t       addr_i,
  output region_evt_t region_evt_o
);

  addr_t       debug_off;
  addr_t       hyper_off;
  logic        in_debug;
  logic        in_hyper;
  region_evt_t region_d;
  region_evt_t region_q;

  // Range checks as offsets from each region base
  assign debug_off = addr_i - DEBUG_BASE;
  assign hyper_off = addr_i - HYPER_BASE;
  assign in_debug  = debug_off < (HYPER_BASE - DEBUG_BASE);
  assign in_hyper  = hyper_off < HYPER_LENGTH;

  always_comb begin
    region_d = '0;
    if (access_valid_i) begin
      if (in_debug) begin
        region_d[0] = 1'b1;
      end else if (in_hyper) begin
        region_d[1] = 1'b1;
      end else begin
        region_d[2] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      region_q <= '0;
    end else begin
      region_q <= region_d;
    end
  end

  assign region_evt_o = region_q;

  a_region_onehot : assert property (@(posedge clk_i) disable iff (rst_i)
                                     $onehot0(region_evt_o))
    else $error("more than one region strobe set");

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the host event testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module host_event_tb \
  -f host_event_top.f -o host_event_sim \
  && ./obj_dir/host_event_sim > sim.log 2>&1 \
  || echo "Build or simulation returned an error"
[ -f sim.log ] && cat sim.log
grep -qx ">>> PASS" sim.log 2>/dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
